//--- vlog.f
src/led_geom_pkg.sv
src/fb_bus_pkg.sv
src/fb_read_if.sv
src/frame_store.sv
src/scan_ctrl.sv
src/led_matrix_top.sv
bench/tb_led_matrix.sv

//--- Bender.yml
package:
  name: led_matrix

sources:
  # packages first, then the read interface
  - src/led_geom_pkg.sv
  - src/fb_bus_pkg.sv
  - src/fb_read_if.sv

  # design
  - src/frame_store.sv
  - src/scan_ctrl.sv
  - src/led_matrix_top.sv

  # testbench, top module tb_led_matrix
  - target: test
    files:
      - bench/tb_led_matrix.sv

# compile with the same order as vlog.f
# RTL top level: led_matrix_top
# simulation top: tb_led_matrix
# default parameters are used throughout
# no include directories are needed

//--- bench/tb_led_matrix.sv
`timescale 1ns/1ps
`default_nettype none
/* runs three frames with the default latch, show and gap lengths
   a pixel written during a frame is compared from the following frame on */
module tb_led_matrix;
	import led_geom_pkg::*;
	import fb_bus_pkg::*;

	localparam int LATCH_CYCLES = 4;
	localparam int SHOW_CYCLES = 8;
	localparam int GAP_CYCLES = 6;
	localparam int COLS = 64;
	localparam int ROWS = 32;
	localparam int PIXELS_PER_FRAME = COLS * ROWS;
	localparam int ROW_CYCLES = COLS * 4 + LATCH_CYCLES + SHOW_CYCLES + GAP_CYCLES;
	localparam int TIMEOUT_CYCLES = 3 * ROWS * ROW_CYCLES + 1000;
	localparam int N_RANDOM = 30;
	localparam int N_FIRST = 24;    // written during frame 0, the rest during frame 1

	typedef struct packed {
		bus_addr_t addr;
		bus_data_t data;
		logic accept;
	} wr_entry_t;

	logic clk;
	logic rst;
	logic wr_en;
	bus_addr_t wr_addr;
	bus_data_t wr_data;
	row_t row_addr;
	col_t col_addr;
	logic display_clk;
	logic latch;
	logic display_oe;
	pixel_t dout_a;
	pixel_t dout_b;

	wr_entry_t wr_table [$];
	pixel_t model [2*PIXELS_PER_FRAME];
	int ready_from [2*PIXELS_PER_FRAME];   // first frame that must show the model value
	int pix_count = 0;
	int checked_count = 0;
	int cycle_count = 0;
	int pulses_in_row = 0;
	int latch_len = 0;
	int oe_len = 0;
	int idle_len = 0;
	int rows_seen = 0;
	int last_row = 0;

	led_matrix_top u_dut (
		.clk         (clk),
		.rst         (rst),
		.wr_en       (wr_en),
		.wr_addr     (wr_addr),
		.wr_data     (wr_data),
		.row_addr    (row_addr),
		.col_addr    (col_addr),
		.display_clk (display_clk),
		.latch       (latch),
		.display_oe  (display_oe),
		.dout_a      (dout_a),
		.dout_b      (dout_b)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic check_value(input string name, input int expected, input int actual);
		if (expected != actual) begin
			$display("FAIL %s expected %0d actual %0d", name, expected, actual);
			$display("TESTBENCH FAILED");
			$fatal(1, "stopping at first mismatch");
		end
	endtask

	// {region, pad, half, row, col, byte offset}
	function automatic bus_addr_t raw_addr(input logic [15:0] region, input logic [1:0] pad,
		input fb_index_t idx);
		return {region, pad, idx, 2'b00};
	endfunction

	function automatic bus_addr_t frame_addr(input logic half, input row_t row, input col_t col);
		return raw_addr(FB_REGION, 2'b00, {half, row, col});
	endfunction

	task automatic add_entry(input bus_addr_t addr, input bus_data_t data, input logic accept);
		wr_entry_t e;
		e.addr = addr;
		e.data = data;
		e.accept = accept;
		wr_table.push_back(e);
	endtask

	task automatic build_table();
		fb_index_t idx;
		logic [15:0] region;
		add_entry(frame_addr(1'b0, 5'd0, 6'd0), 32'h0000_0005, 1'b1);
		add_entry(frame_addr(1'b1, 5'd0, 6'd0), 32'h0000_000a, 1'b1);
		add_entry(frame_addr(1'b0, 5'd31, 6'd63), 32'h0000_000f, 1'b1);
		add_entry(frame_addr(1'b1, 5'd31, 6'd63), 32'h1234_5673, 1'b1);    // upper bits dropped
		add_entry(raw_addr(16'h0003, 2'b00, 12'h000), 32'h0000_0009, 1'b0);
		add_entry(raw_addr(16'h0000, 2'b00, 12'hfff), 32'h0000_0001, 1'b0);
		add_entry(raw_addr(FB_REGION, 2'b01, 12'h7ff), 32'h0000_0002, 1'b0);
		add_entry(raw_addr(FB_REGION, 2'b10, 12'h800), 32'h0000_0003, 1'b0);
		add_entry(frame_addr(1'b0, 5'd5, 6'd17), 32'hffff_fff6, 1'b1);
		add_entry(frame_addr(1'b1, 5'd5, 6'd17) | 32'h3, 32'h0000_000c, 1'b1);
		for (int k = 0; k < N_RANDOM; k++) begin
			idx = fb_index_t'($urandom);
			if (k % 5 == 4) begin
				region = FB_REGION ^ (16'h1 << $urandom_range(15, 0));
				add_entry(raw_addr(region, 2'b00, idx), $urandom, 1'b0);
			end else if (k % 5 == 2) begin
				add_entry(raw_addr(FB_REGION, 2'($urandom_range(3, 1)), idx), $urandom, 1'b0);
			end else begin
				add_entry(raw_addr(FB_REGION, 2'b00, idx), $urandom, 1'b1);
			end
		end
	endtask

	task automatic apply_write(input wr_entry_t e);
		fb_index_t idx;
		idx = e.addr[13:2];
		@(posedge clk);
		wr_en <= 1'b1;
		wr_addr <= e.addr;
		wr_data <= e.data;
		if (e.accept) begin
			model[idx] <= e.data[3:0];
			ready_from[idx] <= pix_count / PIXELS_PER_FRAME + 1;
		end
		@(posedge clk);
		wr_en <= 1'b0;
		repeat ($urandom_range(250, 1)) @(posedge clk);
	endtask

	// outputs are read at the edge, before they update
	always @(posedge clk) begin
		fb_index_t idx_a;
		fb_index_t idx_b;
		int frame_idx;
		if (!rst) begin
			check_value("latch with output enable", 0, int'(latch && !display_oe));
			if (display_clk) begin
				if (pulses_in_row == 0) begin
					if (rows_seen > 0) begin
						check_value("idle cycles before first column", GAP_CYCLES + 2, idle_len);
						check_value("row advance", (last_row + 1) % ROWS, int'(row_addr));
					end
					last_row = row_addr;
					rows_seen++;
					latch_len = 0;
					oe_len = 0;
					idle_len = 0;
				end
				check_value("row held", last_row, int'(row_addr));
				check_value("column order", pulses_in_row, int'(col_addr));
				frame_idx = pix_count / PIXELS_PER_FRAME;
				idx_a = {1'b0, row_addr, col_addr};
				idx_b = {1'b1, row_addr, col_addr};
				if (frame_idx >= 1 && ready_from[idx_a] <= frame_idx) begin
					check_value($sformatf("upper pixel row %0d col %0d", row_addr, col_addr),
						model[idx_a], dout_a);
					checked_count++;
				end
				if (frame_idx >= 1 && ready_from[idx_b] <= frame_idx) begin
					check_value($sformatf("lower pixel row %0d col %0d", row_addr, col_addr),
						model[idx_b], dout_b);
					checked_count++;
				end
				pulses_in_row++;
				pix_count <= pix_count + 1;
			end
			if (latch) begin
				if (latch_len == 0) begin
					check_value("clocks per row", COLS, pulses_in_row);
					pulses_in_row = 0;
				end
				latch_len++;
			end
			if (!display_oe) begin
				if (oe_len == 0) begin
					check_value("latch cycles", LATCH_CYCLES, latch_len);
				end
				oe_len++;
			end
			if (!display_clk && !latch && display_oe && oe_len > 0) begin
				if (idle_len == 0) begin
					check_value("show cycles", SHOW_CYCLES, oe_len);
				end
				idle_len++;
			end
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("scan did not finish three frames within %0d cycles", TIMEOUT_CYCLES);
			$display("TESTBENCH FAILED");
			$fatal(1, "timeout");
		end
	end

	initial begin
		void'($urandom(24534));
		rst = 1'b1;
		wr_en = 1'b0;
		wr_addr = '0;
		wr_data = '0;
		for (int i = 0; i < 2*PIXELS_PER_FRAME; i++) begin
			model[i] = '0;    // store starts all zero
			ready_from[i] = 0;
		end
		build_table();
		repeat (2) @(posedge clk);
		check_value("reset display_clk", 0, display_clk);
		check_value("reset latch", 0, latch);
		check_value("reset display_oe", 1, display_oe);
		check_value("reset row_addr", 0, row_addr);
		check_value("reset col_addr", 0, col_addr);
		rst <= 1'b0;
		for (int i = 0; i < N_FIRST; i++) begin
			apply_write(wr_table[i]);
		end
		wait (pix_count >= PIXELS_PER_FRAME);
		for (int i = N_FIRST; i < wr_table.size(); i++) begin
			apply_write(wr_table[i]);
		end
		wait (pix_count >= 3 * PIXELS_PER_FRAME);
		check_value("rows scanned", 3 * ROWS, rows_seen);
		check_value("pixels compared", 1,
			int'(checked_count >= 4 * PIXELS_PER_FRAME - 2 * wr_table.size()));
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- src/led_matrix_top.sv
`timescale 1ns/1ps
`default_nettype none
/* single-cycle write strobe, no back-pressure; dout_a/dout_b valid while display_clk is high
   one row takes 256 + LATCH_CYCLES + SHOW_CYCLES + GAP_CYCLES clocks */
module led_matrix_top #(
	parameter int LATCH_CYCLES = 4,
	parameter int SHOW_CYCLES = 8,
	parameter int GAP_CYCLES = 6
) (
	input logic clk,
	input logic rst,

	input logic wr_en,
	input fb_bus_pkg::bus_addr_t wr_addr,
	input fb_bus_pkg::bus_data_t wr_data,

	output led_geom_pkg::row_t row_addr,
	output led_geom_pkg::col_t col_addr,
	output logic display_clk,
	output logic latch,
	output logic display_oe,     // active low
	output led_geom_pkg::pixel_t dout_a,
	output led_geom_pkg::pixel_t dout_b
);

	fb_read_if u_rd ();

	frame_store u_store (
		.clk     (clk),
		.rst     (rst),
		.wr_en   (wr_en),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.rd      (u_rd.store)
	);

	scan_ctrl #(
		.LATCH_CYCLES (LATCH_CYCLES),
		.SHOW_CYCLES  (SHOW_CYCLES),
		.GAP_CYCLES   (GAP_CYCLES)
	) u_scan (
		.clk         (clk),
		.rst         (rst),
		.rd          (u_rd.scan),
		.display_clk (display_clk),
		.latch       (latch),
		.display_oe  (display_oe)
	);

	// panel address and data straight off the read port
	assign row_addr = u_rd.row;
	assign col_addr = u_rd.col;
	assign dout_a = u_rd.pix_a;
	assign dout_b = u_rd.pix_b;

endmodule

`default_nettype wire

//--- src/scan_ctrl.sv
`timescale 1ns/1ps
`default_nettype none
/* 4 clocks per column, 64 columns, then latch, show and gap, display_oe is active low
   outputs are registered from the next state; the very first read after reset is skipped */
module scan_ctrl #(
	parameter int LATCH_CYCLES = 4,
	parameter int SHOW_CYCLES = 8,
	parameter int GAP_CYCLES = 6
) (
	input logic clk,
	input logic rst,
	fb_read_if.scan rd,
	output logic display_clk,
	output logic latch,
	output logic display_oe
);
	import led_geom_pkg::*;

	localparam int MAX_LS = (LATCH_CYCLES > SHOW_CYCLES) ? LATCH_CYCLES : SHOW_CYCLES;
	localparam int MAX_HOLD = (MAX_LS > GAP_CYCLES) ? MAX_LS : GAP_CYCLES;
	localparam int CNT_W = $clog2(MAX_HOLD + 1);

	typedef logic [CNT_W-1:0] hold_t;

	localparam hold_t LATCH_LOAD = hold_t'(LATCH_CYCLES - 1);
	localparam hold_t SHOW_LOAD = hold_t'(SHOW_CYCLES - 1);
	localparam hold_t GAP_LOAD = hold_t'(GAP_CYCLES - 1);
	localparam col_t COL_LAST = '1;

	scan_state_t state;
	scan_state_t state_nxt;
	hold_t hold_cnt;    // shared by LATCH, SHOW and GAP
	logic hold_done;
	row_t row_q;
	col_t col_q;
	logic re_q;

	assign hold_done = (hold_cnt == '0);

	assign rd.re = re_q;
	assign rd.row = row_q;
	assign rd.col = col_q;

	always_comb begin
		state_nxt = state;
		case (state)
			FETCH: begin
				state_nxt = DATAWAIT;
			end
			DATAWAIT: begin
				state_nxt = SHIFT_HI;   // store needs a second edge
			end
			SHIFT_HI: begin
				state_nxt = SHIFT_LO;
			end
			SHIFT_LO: begin
				if (col_q == COL_LAST) begin
					state_nxt = LATCH;
				end else begin
					state_nxt = FETCH;
				end
			end
			LATCH: begin
				if (hold_done) begin
					state_nxt = SHOW;
				end
			end
			SHOW: begin
				if (hold_done) begin
					state_nxt = GAP;
				end
			end
			GAP: begin
				if (hold_done) begin
					state_nxt = FETCH;
				end
			end
			default: begin
				state_nxt = FETCH;
			end
		endcase
	end

	// outputs line up with the state they belong to
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= FETCH;
			re_q <= 1'b0;
			display_clk <= 1'b0;
			latch <= 1'b0;
			display_oe <= 1'b1;    // panel off
		end else begin
			state <= state_nxt;
			re_q <= (state_nxt == FETCH);
			display_clk <= (state_nxt == SHIFT_HI);
			latch <= (state_nxt == LATCH);
			display_oe <= (state_nxt != SHOW);
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			hold_cnt <= '0;
		end else begin
			case (state)
				SHIFT_LO: hold_cnt <= LATCH_LOAD;   // only used after the last column
				LATCH: hold_cnt <= hold_done ? SHOW_LOAD : hold_cnt - 1'b1;
				SHOW: hold_cnt <= hold_done ? GAP_LOAD : hold_cnt - 1'b1;
				GAP: hold_cnt <= hold_done ? hold_cnt : hold_cnt - 1'b1;
				default: hold_cnt <= hold_cnt;
			endcase
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			row_q <= '0;
			col_q <= '0;
		end else if (state == SHIFT_LO && col_q != COL_LAST) begin
			col_q <= col_q + 1'b1;
		end else if (state == GAP && hold_done) begin
			col_q <= '0;
			row_q <= row_q + 1'b1;  // 31 wraps to 0
		end
	end

	a_latch_oe_excl: assert property (
		@(posedge clk) disable iff (rst)
		!(latch && !display_oe)
	) else $error("latch and output enable active together");

	a_clk_in_shift: assert property (
		@(posedge clk) disable iff (rst)
		display_clk |-> (state == SHIFT_HI)
	) else $error("display_clk high outside SHIFT_HI");

	a_hold_params: assert property (
		@(posedge clk)
		(LATCH_CYCLES >= 1) && (SHOW_CYCLES >= 1) && (GAP_CYCLES >= 1)
	) else $error("latch, show and gap lengths must be at least 1");

endmodule

`default_nettype wire

//--- src/frame_store.sv
`timescale 1ns/1ps
`default_nettype none
/* writes outside the frame region are dropped, only wr_data[3:0] is kept
   read of a pixel written in the same cycle returns the old value */
module frame_store (
	input logic clk,
	input logic rst,
	input logic wr_en,
	input fb_bus_pkg::bus_addr_t wr_addr,
	input fb_bus_pkg::bus_data_t wr_data,
	fb_read_if.store rd
);
	import fb_bus_pkg::*;
	import led_geom_pkg::*;

	localparam int DEPTH = 1 << FB_IDX_W;

	pixel_t mem [DEPTH];

	fb_index_t wr_idx;
	fb_index_t rd_idx_a;
	fb_index_t rd_idx_b;
	logic region_hit;
	logic pad_zero;
	logic wr_hit;

	pixel_t rd_a_q;     // read stage
	pixel_t rd_b_q;
	pixel_t pix_a_q;    // output stage
	pixel_t pix_b_q;

	// address decode
	assign wr_idx = wr_addr[FB_IDX_LSB +: FB_IDX_W];
	assign region_hit = (wr_addr[BUS_W-1:FB_REGION_LSB] == FB_REGION);
	assign pad_zero = (wr_addr[FB_REGION_LSB-1:FB_IDX_LSB+FB_IDX_W] == '0);
	assign wr_hit = wr_en && region_hit && pad_zero;

	// same row pair, different half
	assign rd_idx_a = {1'b0, rd.row, rd.col};
	assign rd_idx_b = {1'b1, rd.row, rd.col};

	initial begin
		for (int i = 0; i < DEPTH; i++) begin
			mem[i] = '0;
		end
	end

	always @(posedge clk) begin
		if (wr_hit) begin
			mem[wr_idx] <= wr_data[PIXEL_W-1:0];
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rd_a_q <= '0;
			rd_b_q <= '0;
		end else if (rd.re) begin
			rd_a_q <= mem[rd_idx_a];
			rd_b_q <= mem[rd_idx_b];
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			pix_a_q <= '0;
			pix_b_q <= '0;
		end else begin
			pix_a_q <= rd_a_q;   // holds while no new read
			pix_b_q <= rd_b_q;
		end
	end

	assign rd.pix_a = pix_a_q;
	assign rd.pix_b = pix_b_q;

	a_wr_addr_known: assert property (
		@(posedge clk) disable iff (rst)
		wr_en |-> !$isunknown(wr_addr)
	) else $error("write address has unknown bits");

endmodule

`default_nettype wire

//--- src/fb_read_if.sv
`timescale 1ns/1ps
`default_nettype none
/* row and col are sampled while re is high, pixels follow two clock edges later and hold */
interface fb_read_if;
	import led_geom_pkg::*;

	logic re;       // single-cycle read strobe
	row_t row;
	col_t col;
	pixel_t pix_a;  // upper half
	pixel_t pix_b;  // lower half

	modport scan (
		output re,
		output row,
		output col,
		input pix_a,
		input pix_b
	);

	modport store (
		input re,
		input row,
		input col,
		output pix_a,
		output pix_b
	);
endinterface

`default_nettype wire

//--- src/fb_bus_pkg.sv
`default_nettype none
/* frame region sits at upper half-word 0x0002 of the 32-bit bus, word aligned
   pixel index is address bits 13:2, bits 15:14 must be zero */
package fb_bus_pkg;

	localparam int BUS_W = 32;

	typedef logic [BUS_W-1:0] bus_addr_t;   // byte address
	typedef logic [BUS_W-1:0] bus_data_t;

	// index layout is {half, row, col}, half 0 = upper panel half
	localparam int FB_IDX_W = 12;
	localparam int FB_IDX_LSB = 2;          // word aligned
	localparam int FB_REGION_LSB = 16;

	typedef logic [FB_IDX_W-1:0] fb_index_t;

	localparam logic [15:0] FB_REGION = 16'h0002;

endpackage

`default_nettype wire

//--- src/led_geom_pkg.sv
`default_nettype none
/* 64x64 panel driven as 32 row pairs, 64 columns per row, 4-bit colour code per pixel
   row and column counters wrap naturally at these widths */
package led_geom_pkg;

	localparam int ROW_W = 5;    // row pairs, upper and lower half share one address
	localparam int COL_W = 6;
	localparam int PIXEL_W = 4;

	typedef logic [ROW_W-1:0] row_t;
	typedef logic [COL_W-1:0] col_t;
	typedef logic [PIXEL_W-1:0] pixel_t;

	// per column FETCH..SHIFT_LO, per row LATCH, SHOW, GAP
	typedef enum logic [2:0] {
		FETCH    = 3'd0,
		DATAWAIT = 3'd1,
		SHIFT_HI = 3'd2,
		SHIFT_LO = 3'd3,
		LATCH    = 3'd4,
		SHOW     = 3'd5,
		GAP      = 3'd6
	} scan_state_t;

endpackage

`default_nettype wire
